// File: tb.f
+incdir+include
src/mix_pkg.sv
src/gain_stage.sv
src/sample_fifo.sv
src/sum_quantizer.sv
src/dac_combiner.sv
tb/dac_combiner_props.sv
tb/dac_combiner_tb.sv

// File: Bender.yml
package:
  name: dac_combiner

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/mix_pkg.sv
      - src/gain_stage.sv
      - src/sample_fifo.sv
      - src/sum_quantizer.sv
      - src/dac_combiner.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dac_combiner_props.sv
      - tb/dac_combiner_tb.sv

// File: tb/dac_combiner_tb.sv
`timescale 1ns/10ps
`include "mix_settings.svh"

module dac_combiner_tb;
    import mix_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_GAIN      = 40;
    localparam int N_SAT       = 8;
    localparam int N_MIX       = 30;
    localparam int N_PER_SHIFT = 24;
    localparam int TOTAL_BEATS = 1 + N_GAIN + N_SAT + N_MIX + 8 * N_PER_SHIFT;
    // 40 cycles per beat is far beyond the worst back-pressure
    localparam int TIMEOUT_NS  = TOTAL_BEATS * 40 * CLK_PERIOD;

    typedef struct packed {
        dac_code_t code;
        logic      clip;
    } exp_t;

    logic       sys_clk;
    logic       rst;
    logic       i_in_valid;
    logic       o_in_ready;
    lane_vec_t  i_lanes;
    src_sel_e   i_src_sel;
    gain_vec_t  i_gains;
    sample_t    i_cpu_sample;
    ramp_step_t i_ramp_step;
    shift_t     i_final_shift;
    logic       o_out_valid;
    logic       i_out_ready;
    dac_code_t  o_dac_code;
    logic       o_clip;

    // scoreboard state
    exp_t                   exp_q[$];
    exp_t                   exp_head;
    logic [`MIX_RAMP_W-1:0] ramp_acc;
    logic                   bp_en;
    int                     code_errs;
    int                     clip_errs;
    int                     other_errs;
    int unsigned            seed_ret;

    dac_combiner u_dac_combiner (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_in_valid    (i_in_valid),
        .o_in_ready    (o_in_ready),
        .i_lanes       (i_lanes),
        .i_src_sel     (i_src_sel),
        .i_gains       (i_gains),
        .i_cpu_sample  (i_cpu_sample),
        .i_ramp_step   (i_ramp_step),
        .i_final_shift (i_final_shift),
        .o_out_valid   (o_out_valid),
        .i_out_ready   (i_out_ready),
        .o_dac_code    (o_dac_code),
        .o_clip        (o_clip)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic exp_t ref_result(
        input lane_vec_t              lanes,
        input src_sel_e               src,
        input gain_vec_t              gains,
        input sample_t                cpu,
        input logic [`MIX_RAMP_W-1:0] acc,
        input shift_t                 sh
    );
        exp_t    r;
        longint  prod;
        sample_t lane;
        int      sum;
        int      q;
        sum = 0;
        for (int ch = 0; ch < `MIX_NUM_CH; ch++) begin
            case (src)
                SRC_CPU:  lane = cpu;
                // top 12 bits recentred, times 16
                SRC_RAMP: lane = sample_t'((int'(acc >> 4) - 2048) * 16);
                default: begin
                    prod = longint'(lanes[ch]) * longint'(gains[ch]);
                    lane = sample_t'(prod >>> 30);
                end
            endcase
            sum += lane;
        end
        // round half up before the shift
        if (sh != 0) begin
            sum += 1 << (sh - 1);
        end
        q = sum >>> sh;
        r.clip = (q > 8191) || (q < -8192);
        if (q > 8191) begin
            q = 8191;
        end else if (q < -8192) begin
            q = -8192;
        end
        // offset binary = two's complement plus half range
        r.code = dac_code_t'(q + 8192);
        return r;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_code(input dac_code_t got, input dac_code_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: dac code got %0d expected %0d", $time, got, exp);
            code_errs++;
        end
    endtask

    task automatic check_clip(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: clip flag got %b expected %b", $time, got, exp);
            clip_errs++;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    // uniform lanes in -amp..amp
    function automatic lane_vec_t rand_lanes(input int amp);
        lane_vec_t v;
        for (int ch = 0; ch < `MIX_NUM_CH; ch++) begin
            v[ch] = sample_t'(int'($urandom % (2 * amp + 1)) - amp);
        end
        return v;
    endfunction

    function automatic lane_vec_t same_lanes(input sample_t s);
        lane_vec_t v;
        for (int ch = 0; ch < `MIX_NUM_CH; ch++) begin
            v[ch] = s;
        end
        return v;
    endfunction

    // called right after a rising edge, returns on the accepting edge
    task automatic send_beat(input lane_vec_t lanes, input src_sel_e src);
        i_in_valid <= 1'b1;
        i_lanes    <= lanes;
        i_src_sel  <= src;
        do @(posedge sys_clk); while (!o_in_ready);
        i_in_valid <= 1'b0;
    endtask

    task automatic idle_gap();
        repeat ($urandom % 3) @(posedge sys_clk);
    endtask

    // wait until every expected beat has come out
    task automatic drain();
        bp_en = 1'b0;
        i_out_ready <= 1'b1;
        do @(posedge sys_clk); while (exp_q.size() != 0);
    endtask

    // ------------------------------------------------------------
    // scoreboard processes
    // ------------------------------------------------------------
    // input side, ramp mirror steps on any accepted beat
    always @(posedge sys_clk) begin
        if (rst) begin
            ramp_acc = '0;
        end else if (i_in_valid && o_in_ready) begin
            exp_q.push_back(ref_result(i_lanes, i_src_sel, i_gains, i_cpu_sample,
                                       ramp_acc, i_final_shift));
            ramp_acc = ramp_acc + `MIX_RAMP_W'(i_ramp_step);
        end
    end

    // output side
    always @(posedge sys_clk) begin
        if (!rst && o_out_valid && i_out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat at %0t arrived with no input beat pending", $time);
                other_errs++;
            end else begin
                exp_head = exp_q.pop_front();
                check_code(o_dac_code, exp_head.code);
                check_clip(o_clip, exp_head.clip);
            end
        end
    end

    // random output stall, about half the time
    always @(posedge sys_clk) begin
        if (bp_en) begin
            i_out_ready <= 1'($urandom % 2);
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the pipeline stopped delivering beats", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed_ret = $urandom(44866);
        sys_clk       = 1'b0;
        rst           = 1'b1;
        i_in_valid    = 1'b0;
        i_lanes       = '0;
        i_src_sel     = SRC_GAINED;
        i_gains       = {`MIX_NUM_CH{32'h4000_0000}};
        i_cpu_sample  = '0;
        i_ramp_step   = '0;
        i_final_shift = '0;
        i_out_ready   = 1'b1;
        bp_en         = 1'b0;
        code_errs     = 0;
        clip_errs     = 0;
        other_errs    = 0;
        repeat (4) @(posedge sys_clk);
        rst <= 1'b0;
        @(posedge sys_clk);

        // idle state, then a single beat
        if (o_out_valid !== 1'b0 || o_in_ready !== 1'b1) begin
            $display("[ERROR] %0t: after reset out_valid %b in_ready %b", $time,
                     o_out_valid, o_in_ready);
            other_errs++;
        end
        send_beat(rand_lanes(4000), SRC_GAINED);
        drain();

        // gains near unity, shift 3
        for (int ch = 0; ch < `MIX_NUM_CH; ch++) begin
            i_gains[ch] <= 32'h3f00_0000 + ($urandom % 32'h0200_0000);
        end
        i_final_shift <= 3'd3;
        for (int n = 0; n < N_GAIN; n++) begin
            send_beat(rand_lanes(32767), SRC_GAINED);
            idle_gap();
        end
        drain();

        // saturation both ways, then small lanes
        i_gains       <= {`MIX_NUM_CH{32'h4000_0000}};
        i_final_shift <= 3'd0;
        for (int n = 0; n < 3; n++) begin
            send_beat(same_lanes(16'sd30000), SRC_GAINED);
        end
        for (int n = 0; n < 3; n++) begin
            send_beat(same_lanes(-16'sd30000), SRC_GAINED);
        end
        for (int n = 0; n < N_SAT - 6; n++) begin
            send_beat(rand_lanes(1000), SRC_GAINED);
        end
        drain();

        // cpu and ramp mixed with gained beats
        i_cpu_sample  <= sample_t'(int'($urandom % 3001) - 1500);
        i_ramp_step   <= ramp_step_t'($urandom) | 12'd1;
        i_final_shift <= 3'd2;
        for (int n = 0; n < N_MIX; n++) begin
            send_beat(rand_lanes(32767), src_sel_e'($urandom % 3));
        end
        drain();

        // shift sweep under random stalls and gaps
        for (int s = 0; s < 8; s++) begin
            i_final_shift <= shift_t'(s);
            bp_en = 1'b1;
            for (int n = 0; n < N_PER_SHIFT; n++) begin
                send_beat(rand_lanes(32767), SRC_GAINED);
                idle_gap();
            end
            drain();
        end

        repeat (4) @(posedge sys_clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out of the DUT", exp_q.size());
            other_errs++;
        end
        $display("error counts: code %0d, clip %0d, other %0d",
                 code_errs, clip_errs, other_errs);
        if (code_errs + clip_errs + other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb/dac_combiner_props.sv
`timescale 1ns/10ps
`include "mix_settings.svh"

module dac_combiner_props (
    input logic               sys_clk,
    input logic               rst,
    input logic               i_in_valid,
    input logic               i_in_ready,
    input logic               i_out_valid,
    input logic               i_out_ready,
    input mix_pkg::dac_code_t i_dac_code,
    input logic               i_clip,
    input logic               i_fifo_in_valid,
    input logic               i_fifo_in_ready,
    input logic               i_fifo_out_valid,
    input logic               i_fifo_out_ready
);
    localparam int FIFO_DEPTH = `MIX_FIFO_DEPTH;

    // set by the first accepted input beat
    logic in_seen_q;
    // beats held in the sample FIFO, counted from its handshakes
    int   fifo_fill_q;
    logic fifo_wr;
    logic fifo_rd;

    assign fifo_wr = i_fifo_in_valid && i_fifo_in_ready;
    assign fifo_rd = i_fifo_out_valid && i_fifo_out_ready;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            in_seen_q <= 1'b0;
        end else if (i_in_valid && i_in_ready) begin
            in_seen_q <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            fifo_fill_q <= 0;
        end else begin
            fifo_fill_q <= fifo_fill_q + (fifo_wr ? 1 : 0) - (fifo_rd ? 1 : 0);
        end
    end

    // ------------------------------------------------------------
    // handshake and reset properties
    // ------------------------------------------------------------
    out_quiet_after_reset: assert property (@(posedge sys_clk) disable iff (rst)
        !in_seen_q |-> !i_out_valid)
        else $error("output valid before any input beat was accepted");

    // stalled output holds its beat
    out_held_on_stall: assert property (@(posedge sys_clk) disable iff (rst)
        (i_out_valid && !i_out_ready) |=>
            (i_out_valid && $stable(i_dac_code) && $stable(i_clip)))
        else $error("output beat changed while stalled");

    fifo_no_overflow: assert property (@(posedge sys_clk) disable iff (rst)
        fifo_wr |-> (fifo_fill_q < FIFO_DEPTH))
        else $error("sample FIFO written while full");

endmodule

bind dac_combiner dac_combiner_props u_dac_combiner_props (
    .sys_clk          (sys_clk),
    .rst              (rst),
    .i_in_valid       (i_in_valid),
    .i_in_ready       (o_in_ready),
    .i_out_valid      (o_out_valid),
    .i_out_ready      (i_out_ready),
    .i_dac_code       (o_dac_code),
    .i_clip           (o_clip),
    .i_fifo_in_valid  (gs_valid),
    .i_fifo_in_ready  (gs_ready),
    .i_fifo_out_valid (ff_valid),
    .i_fifo_out_ready (ff_ready)
);

// File: src/dac_combiner.sv
`timescale 1ns/10ps

module dac_combiner (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                i_in_valid,
    output logic                o_in_ready,
    input  mix_pkg::lane_vec_t  i_lanes,
    input  mix_pkg::src_sel_e   i_src_sel,
    input  mix_pkg::gain_vec_t  i_gains,
    input  mix_pkg::sample_t    i_cpu_sample,
    input  mix_pkg::ramp_step_t i_ramp_step,
    input  mix_pkg::shift_t     i_final_shift,
    output logic                o_out_valid,
    input  logic                i_out_ready,
    output mix_pkg::dac_code_t  o_dac_code,
    output logic                o_clip
);
    import mix_pkg::*;

    // ------------------------------------------------------------
    // gain stage -> fifo -> sum tree
    // ------------------------------------------------------------
    logic      gs_valid, gs_ready;
    lane_vec_t gs_lanes;
    logic      ff_valid, ff_ready;
    lane_vec_t ff_lanes;

    gain_stage u_gain_stage (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .i_valid      (i_in_valid),
        .o_ready      (o_in_ready),
        .i_lanes      (i_lanes),
        .i_src_sel    (i_src_sel),
        .i_gains      (i_gains),
        .i_cpu_sample (i_cpu_sample),
        .i_ramp_step  (i_ramp_step),
        .o_valid      (gs_valid),
        .i_ready      (gs_ready),
        .o_lanes      (gs_lanes)
    );

    // absorbs output back-pressure
    sample_fifo u_sample_fifo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .i_valid (gs_valid),
        .o_ready (gs_ready),
        .i_lanes (gs_lanes),
        .o_valid (ff_valid),
        .i_ready (ff_ready),
        .o_lanes (ff_lanes)
    );

    sum_quantizer u_sum_quantizer (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_valid       (ff_valid),
        .o_ready       (ff_ready),
        .i_lanes       (ff_lanes),
        .i_final_shift (i_final_shift),
        .o_valid       (o_out_valid),
        .i_ready       (i_out_ready),
        .o_dac_code    (o_dac_code),
        .o_clip        (o_clip)
    );

endmodule

// File: src/sum_quantizer.sv
`timescale 1ns/10ps
`include "mix_settings.svh"

module sum_quantizer (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                i_valid,
    output logic                o_ready,
    input  mix_pkg::lane_vec_t  i_lanes,
    input  mix_pkg::shift_t     i_final_shift,
    output logic                o_valid,
    input  logic                i_ready,
    output mix_pkg::dac_code_t  o_dac_code,
    output logic                o_clip
);
    import mix_pkg::*;

    localparam int SAMPLE_W = `MIX_SAMPLE_W;
    localparam int DAC_W    = `MIX_DAC_W;
    // 16 -> 17 -> 18 -> 19 through the tree
    localparam int SUM_W    = SAMPLE_W + 3;
    localparam logic signed [SUM_W-1:0] SAT_MAX = 2**(DAC_W-1) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(2**(DAC_W-1));

    logic                      v1_q, v2_q, v3_q;
    logic                      advance;
    logic signed [SAMPLE_W:0]   s1_pair0_q, s1_pair1_q;
    logic signed [SAMPLE_W-1:0] s1_lane4_q;
    logic signed [SAMPLE_W+1:0] s2_sum_q, s2_lane4_q;
    logic signed [SUM_W-1:0]    total;
    logic signed [SUM_W-1:0]    rnd_bias;
    logic signed [SUM_W-1:0]    shifted;
    logic signed [DAC_W-1:0]    sat;
    logic                      clip;
    dac_code_t                 code_q;
    logic                      clip_q;

    // whole pipe moves as one
    assign advance = !v3_q || i_ready;
    assign o_ready = advance;

    // ------------------------------------------------------------
    // valid bits
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else if (advance) begin
            v1_q <= i_valid;
            v2_q <= v1_q;
            v3_q <= v2_q;
        end
    end

    // ------------------------------------------------------------
    // sum tree, stages 1 and 2
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (advance && i_valid) begin
            s1_pair0_q <= $signed(i_lanes[0]) + $signed(i_lanes[1]);
            s1_pair1_q <= $signed(i_lanes[2]) + $signed(i_lanes[3]);
            s1_lane4_q <= $signed(i_lanes[4]);
        end
        if (advance && v1_q) begin
            s2_sum_q   <= s1_pair0_q + s1_pair1_q;
            // sign-extend the odd lane
            s2_lane4_q <= s1_lane4_q;
        end
    end

    // ------------------------------------------------------------
    // stage 3: total, round, shift, saturate
    // ------------------------------------------------------------
    assign total = s2_sum_q + s2_lane4_q;

    always_comb begin
        // half an lsb of the shifted result
        if (i_final_shift != 3'd0) begin
            rnd_bias = {{(SUM_W-1){1'b0}}, 1'b1} << (i_final_shift - 3'd1);
        end else begin
            rnd_bias = '0;
        end
        shifted = (total + rnd_bias) >>> i_final_shift;
        clip    = 1'b1;
        if (shifted > SAT_MAX) begin
            sat = SAT_MAX[DAC_W-1:0];
        end else if (shifted < SAT_MIN) begin
            sat = SAT_MIN[DAC_W-1:0];
        end else begin
            sat  = shifted[DAC_W-1:0];
            clip = 1'b0;
        end
    end

    // offset binary: flip the sign bit
    always_ff @(posedge sys_clk) begin
        if (advance && v2_q) begin
            code_q <= {~sat[DAC_W-1], sat[DAC_W-2:0]};
            clip_q <= clip;
        end
    end

    assign o_valid    = v3_q;
    assign o_dac_code = code_q;
    assign o_clip     = clip_q;

endmodule

// File: src/sample_fifo.sv
`timescale 1ns/10ps
`include "mix_settings.svh"

module sample_fifo #(
    parameter int DEPTH = `MIX_FIFO_DEPTH
) (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               i_valid,
    output logic               o_ready,
    input  mix_pkg::lane_vec_t i_lanes,
    output logic               o_valid,
    input  logic               i_ready,
    output mix_pkg::lane_vec_t o_lanes
);
    import mix_pkg::*;

    // index width, pointers carry one extra wrap bit
    localparam int AW = $clog2(DEPTH);

    lane_vec_t     mem [DEPTH];
    logic [AW:0]   wr_ptr_q;
    logic [AW:0]   rd_ptr_q;
    logic          full;
    logic          empty;
    logic          wr_en;
    logic          rd_en;

    // ------------------------------------------------------------
    // occupancy
    // ------------------------------------------------------------
    // same index, different lap -> full
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW])
                && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);

    assign o_ready = !full;
    assign o_valid = !empty;

    assign wr_en = i_valid && o_ready;
    assign rd_en = o_valid && i_ready;

    // ------------------------------------------------------------
    // pointers
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            // both may move in the same cycle
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_ptr_q[AW-1:0]] <= i_lanes;
        end
    end

    // head of queue, shows up the cycle after the write
    assign o_lanes = mem[rd_ptr_q[AW-1:0]];

endmodule

// File: src/gain_stage.sv
`timescale 1ns/10ps
`include "mix_settings.svh"

module gain_stage (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                i_valid,
    output logic                o_ready,
    input  mix_pkg::lane_vec_t  i_lanes,
    input  mix_pkg::src_sel_e   i_src_sel,
    input  mix_pkg::gain_vec_t  i_gains,
    input  mix_pkg::sample_t    i_cpu_sample,
    input  mix_pkg::ramp_step_t i_ramp_step,
    output logic                o_valid,
    input  logic                i_ready,
    output mix_pkg::lane_vec_t  o_lanes
);
    import mix_pkg::*;

    localparam int NUM_CH      = `MIX_NUM_CH;
    localparam int SAMPLE_W    = `MIX_SAMPLE_W;
    localparam int GAIN_W      = `MIX_GAIN_W;
    localparam int GAIN_FRAC   = `MIX_GAIN_FRAC;
    localparam int RAMP_W      = `MIX_RAMP_W;
    localparam int RAMP_STEP_W = `MIX_RAMP_STEP_W;
    // signed sample times zero-extended gain
    localparam int PROD_W      = SAMPLE_W + GAIN_W + 1;

    logic                     out_valid_q;
    lane_vec_t                out_lanes_q;
    logic                     accept;
    logic [RAMP_W-1:0]        ramp_acc_q;
    logic signed [RAMP_STEP_W:0] ramp_c;
    sample_t                  ramp_sample;
    logic signed [PROD_W-1:0] prod [NUM_CH];
    lane_vec_t                next_lanes;

    // one-deep skid-less output register
    assign o_ready = !out_valid_q || i_ready;
    assign accept  = i_valid && o_ready;

    // ------------------------------------------------------------
    // test ramp
    // ------------------------------------------------------------
    // top bits of the accumulator, recentred around zero
    assign ramp_c = $signed({1'b0, ramp_acc_q[RAMP_W-1 -: RAMP_STEP_W]})
                  - $signed({1'b0, 1'b1, {(RAMP_STEP_W-1){1'b0}}});
    // widen to a full-scale lane sample
    assign ramp_sample = {ramp_c[RAMP_STEP_W-1:0], {(SAMPLE_W-RAMP_STEP_W){1'b0}}};

    // steps once per accepted beat, any source
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            ramp_acc_q <= '0;
        end else if (accept) begin
            ramp_acc_q <= ramp_acc_q + {{(RAMP_W-RAMP_STEP_W){1'b0}}, i_ramp_step};
        end
    end

    // ------------------------------------------------------------
    // per-lane gain and source mux
    // ------------------------------------------------------------
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            prod[ch] = $signed(i_lanes[ch]) * $signed({1'b0, i_gains[ch]});
            case (i_src_sel)
                SRC_CPU:  next_lanes[ch] = i_cpu_sample;
                SRC_RAMP: next_lanes[ch] = ramp_sample;
                // >>> 30 then keep 16 bits
                default:  next_lanes[ch] = prod[ch][GAIN_FRAC +: SAMPLE_W];
            endcase
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (i_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            out_lanes_q <= next_lanes;
        end
    end

    assign o_valid = out_valid_q;
    assign o_lanes = out_lanes_q;

endmodule

// File: src/mix_pkg.sv
`include "mix_settings.svh"

package mix_pkg;

    // ------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------
    // one signed lane sample
    typedef logic signed [`MIX_SAMPLE_W-1:0] sample_t;

    // all lanes of one beat, lane 0 in the low bits
    typedef sample_t [`MIX_NUM_CH-1:0] lane_vec_t;

    // per-lane gain, unsigned with 30 fraction bits
    typedef logic [`MIX_GAIN_W-1:0] gain_t;
    typedef gain_t [`MIX_NUM_CH-1:0] gain_vec_t;

    // final arithmetic shift, 0 to 7
    typedef logic [2:0] shift_t;

    // ramp increment per accepted beat
    typedef logic [`MIX_RAMP_STEP_W-1:0] ramp_step_t;

    // offset-binary dac word
    typedef logic [`MIX_DAC_W-1:0] dac_code_t;

    // lane source per beat
    typedef enum logic [1:0] {
        SRC_GAINED = 2'd0,
        SRC_CPU    = 2'd1,
        SRC_RAMP   = 2'd2
    } src_sel_e;

endpackage

// File: include/mix_settings.svh
`ifndef MIX_SETTINGS_SVH
`define MIX_SETTINGS_SVH

// ------------------------------------------------------------
// lane count and sample width
// ------------------------------------------------------------
// sum tree is built for exactly five lanes
`define MIX_NUM_CH       5
`define MIX_SAMPLE_W     16

// unsigned gain, q2.30
`define MIX_GAIN_W       32
`define MIX_GAIN_FRAC    30

// dac code width, offset binary
`define MIX_DAC_W        14

// test ramp accumulator and step
`define MIX_RAMP_W       16
`define MIX_RAMP_STEP_W  12

// default sample buffer depth, power of two
`define MIX_FIFO_DEPTH   4

`endif
